//--- background_fill.sv
/* background fill
   raster scan of the whole screen in the background colour */
`timescale 1ns/1ps
`include "gm_settings.svh"

module background_fill
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	output pixel_t pix,
	output logic valid,
	output logic done
);

	logic active;
	logic [8:0] x_cnt;
	logic [7:0] y_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			done <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				active <= 1'b1;
				x_cnt <= '0;
				y_cnt <= '0;
			end else if (active) begin
				// x runs fastest, y steps at the right edge
				if (x_cnt == 9'(`SCREEN_W - 1)) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 1'b1;
					if (y_cnt == 8'(`SCREEN_H - 1)) begin
						active <= 1'b0;
						done <= 1'b1;
					end
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	assign valid = active;
	assign pix = '{x: x_cnt, y: y_cnt, color: `COLOR_BG};

endmodule

//--- game_timer.sv
/* game timer
   one second prescaler feeding a seconds down counter */
`timescale 1ns/1ps
`include "gm_settings.svh"

module game_timer (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic run,
	output logic [7:0] time_remain,
	output logic time_up
);

	localparam int PRESC_W = $clog2(`TICKS_PER_SECOND);

	logic [PRESC_W-1:0] presc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			presc <= '0;
			time_remain <= 8'(`GAME_SECONDS);
		end else if (load) begin
			presc <= '0;
			time_remain <= 8'(`GAME_SECONDS);
		end else if (run && !time_up) begin
			// one second elapsed
			if (presc == PRESC_W'(`TICKS_PER_SECOND - 1)) begin
				presc <= '0;
				time_remain <= time_remain - 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

	// holds until the next load
	assign time_up = (time_remain == 8'd0);

endmodule

//--- game_view.sv
/* game view top
   joins controller, item table, drawers, timer, arbiter and time display */
`timescale 1ns/1ps
`include "gm_settings.svh"

module game_view
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic go,
	input logic item_load,
	input logic [`ITEM_IDX_W-1:0] item_index,
	input item_word_u item_word,
	output pixel_t pixel,
	output logic pixel_we,
	output logic game_over,
	output seg7_t hex0,
	output seg7_t hex1
);

	// controller handshakes
	logic bg_start;
	logic bg_done;
	logic spr_start;
	logic spr_done;
	logic timer_load;
	logic timer_run;
	logic time_up;
	logic [`ITEM_IDX_W-1:0] rd_index;
	draw_src_t src;

	// drawer outputs
	item_word_u rd_word;
	pixel_t bg_pix;
	pixel_t spr_pix;
	logic bg_valid;
	logic spr_valid;
	logic [7:0] time_remain;

	view_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.bg_done(bg_done),
		.spr_done(spr_done),
		.time_up(time_up),
		.bg_start(bg_start),
		.spr_start(spr_start),
		.timer_load(timer_load),
		.timer_run(timer_run),
		.item_index(rd_index),
		.src(src),
		.game_over(game_over)
	);

	item_table u_table (
		.clk(clk),
		.rst_n(rst_n),
		.item_load(item_load),
		.load_index(item_index),
		.load_word(item_word),
		.read_index(rd_index),
		.read_word(rd_word)
	);

	background_fill u_bg (
		.clk(clk),
		.rst_n(rst_n),
		.start(bg_start),
		.pix(bg_pix),
		.valid(bg_valid),
		.done(bg_done)
	);

	sprite_draw u_spr (
		.clk(clk),
		.rst_n(rst_n),
		.start(spr_start),
		.item(rd_word),
		.pix(spr_pix),
		.valid(spr_valid),
		.done(spr_done)
	);

	game_timer u_timer (
		.clk(clk),
		.rst_n(rst_n),
		.load(timer_load),
		.run(timer_run),
		.time_remain(time_remain),
		.time_up(time_up)
	);

	pixel_arbiter u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.src(src),
		.bg_pix(bg_pix),
		.spr_pix(spr_pix),
		.bg_valid(bg_valid),
		.spr_valid(spr_valid),
		.pixel(pixel),
		.pixel_we(pixel_we)
	);

	// remaining seconds as two hex digits
	seg7_decode u_hex0 (
		.digit(time_remain[3:0]),
		.seg(hex0)
	);

	seg7_decode u_hex1 (
		.digit(time_remain[7:4]),
		.seg(hex1)
	);

endmodule

//--- game_view_sva.sv
/* game view output checks
   bound to the top, watches the pixel port and the drawer start pulses */
`timescale 1ns/1ps

module game_view_sva
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic pixel_we,
	input pixel_t pixel,
	input logic game_over,
	input logic bg_start,
	input logic spr_start,
	input draw_src_t src
);

	// a sprite pixel of colour zero never reaches the port
	a_no_transparent_write: assert property (@(posedge clk) disable iff (!rst_n)
		(pixel_we && $past(src) == SRC_SPR) |-> pixel.color != 12'd0)
		else $error("sprite pixel of colour zero was written");

	// nothing is drawn once the game has ended
	a_quiet_when_over: assert property (@(posedge clk) disable iff (!rst_n)
		game_over |-> !pixel_we)
		else $error("pixel write while game_over is high");

	// one drawer at a time
	a_single_start: assert property (@(posedge clk) disable iff (!rst_n)
		!(bg_start && spr_start))
		else $error("bg_start and spr_start pulsed in the same cycle");

endmodule

bind game_view game_view_sva u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.pixel_we(pixel_we),
	.pixel(pixel),
	.game_over(game_over),
	.bg_start(bg_start),
	.spr_start(spr_start),
	.src(src)
);

//--- gm_pkg.sv
/* game view types
   pixel, item word and segment types used across the drawing blocks */
package gm_pkg;

	// one pixel on its way to the frame buffer
	typedef struct packed {
		logic [8:0] x;
		logic [7:0] y;
		logic [11:0] color;
	} pixel_t;

	typedef enum logic [1:0] {
		KIND_STONE,
		KIND_GOLD,
		KIND_DIAMOND,
		KIND_EMPTY
	} item_kind_t;

	// bit layout of a stored item, x in the top bits
	typedef struct packed {
		logic [8:0] x;
		logic [3:0] pad_a;
		logic [7:0] y;
		item_kind_t kind;
		logic [6:0] pad_b;
		logic visible;
		logic pad_c;
	} item_fields_t;

	// table keeps the raw word, drawer reads the fields
	typedef union packed {
		logic [31:0] raw;
		item_fields_t fields;
	} item_word_u;

	// which drawer owns the pixel port
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_BG,
		SRC_SPR
	} draw_src_t;

	// active low, bit 6 is segment g
	typedef logic [6:0] seg7_t;

endpackage

//--- gm_settings.svh
/* game view settings
   screen geometry, sprite size, item table depth, timer rate and palette */
`ifndef GM_SETTINGS_SVH
`define GM_SETTINGS_SVH

// display geometry in pixels
`define SCREEN_W 320
`define SCREEN_H 240
`define SPRITE_SIZE 16

// item table depth and its index width
`define ITEM_COUNT 4
`define ITEM_IDX_W 2

// countdown start, and clocks per second (small for simulation)
`define GAME_SECONDS 30
`define TICKS_PER_SECOND 2000

// 12-bit rgb palette, empty items stay transparent
`define COLOR_BG 12'h4A8
`define COLOR_STONE 12'h888
`define COLOR_GOLD 12'hFC0
`define COLOR_DIAMOND 12'h0EF
`define COLOR_EMPTY 12'h000

`endif

//--- item_table.sv
/* item table
   small register file of item words, loaded by strobe, read by index */
`timescale 1ns/1ps
`include "gm_settings.svh"

module item_table
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic item_load,
	input logic [`ITEM_IDX_W-1:0] load_index,
	input item_word_u load_word,
	input logic [`ITEM_IDX_W-1:0] read_index,
	output item_word_u read_word
);

	item_word_u regs [`ITEM_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// all-zero word has visible low
			for (int i = 0; i < `ITEM_COUNT; i++)
				regs[i].raw <= '0;
		end else if (item_load) begin
			regs[load_index].raw <= load_word.raw;
		end
	end

	// combinational read for the sprite drawer
	assign read_word = regs[read_index];

endmodule

//--- pixel_arbiter.sv
/* pixel arbiter
   picks the owning drawer's pixel, drops transparent sprite pixels, registers */
`timescale 1ns/1ps

module pixel_arbiter
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input draw_src_t src,
	input pixel_t bg_pix,
	input pixel_t spr_pix,
	input logic bg_valid,
	input logic spr_valid,
	output pixel_t pixel,
	output logic pixel_we
);

	// pixel payload
	always_ff @(posedge clk) begin
		if (src == SRC_SPR)
			pixel <= spr_pix;
		else if (src == SRC_BG)
			pixel <= bg_pix;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pixel_we <= 1'b0;
		end else begin
			case (src)
				SRC_BG: pixel_we <= bg_valid;
				// colour zero is see-through
				SRC_SPR: pixel_we <= spr_valid && (spr_pix.color != 12'd0);
				default: pixel_we <= 1'b0;
			endcase
		end
	end

endmodule

//--- project.f
+incdir+.
gm_pkg.sv
view_ctrl.sv
item_table.sv
background_fill.sv
sprite_draw.sv
game_timer.sv
seg7_decode.sv
pixel_arbiter.sv
game_view.sv
game_view_sva.sv
tb_game_view.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the game view testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_game_view -Mdir obj_dir -o sim_game_view
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_game_view > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All checks passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- seg7_decode.sv
/* seven segment decoder
   hex digit to active low segment pattern */
`timescale 1ns/1ps

module seg7_decode
	import gm_pkg::*;
(
	input logic [3:0] digit,
	output seg7_t seg
);

	// segment order gfedcba, low lights
	always_comb begin
		case (digit)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b0000011;
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001;
			4'hE: seg = 7'b0000110;
			4'hF: seg = 7'b0001110;
		endcase
	end

endmodule

//--- sprite_draw.sv
/* sprite drawer
   scans one item as a solid square at its origin in its kind's colour */
`timescale 1ns/1ps
`include "gm_settings.svh"

module sprite_draw
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input item_word_u item,
	output pixel_t pix,
	output logic valid,
	output logic done
);

	localparam int SIDE_W = $clog2(`SPRITE_SIZE);

	item_word_u cur;
	logic active;
	logic [SIDE_W-1:0] dx;
	logic [SIDE_W-1:0] dy;
	logic [11:0] color;

	// item held for the whole scan
	always_ff @(posedge clk) begin
		if (start)
			cur <= item;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			done <= 1'b0;
			dx <= '0;
			dy <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				dx <= '0;
				dy <= '0;
				// hidden item finishes right away
				active <= item.fields.visible;
				done <= !item.fields.visible;
			end else if (active) begin
				if (dx == SIDE_W'(`SPRITE_SIZE - 1)) begin
					dx <= '0;
					dy <= dy + 1'b1;
					if (dy == SIDE_W'(`SPRITE_SIZE - 1)) begin
						active <= 1'b0;
						done <= 1'b1;
					end
				end else begin
					dx <= dx + 1'b1;
				end
			end
		end
	end

	// palette, empty gives colour zero
	always_comb begin
		case (cur.fields.kind)
			KIND_STONE: color = `COLOR_STONE;
			KIND_GOLD: color = `COLOR_GOLD;
			KIND_DIAMOND: color = `COLOR_DIAMOND;
			default: color = `COLOR_EMPTY;
		endcase
	end

	// no clipping, coordinates wrap at the field width
	assign pix = '{x: cur.fields.x + 9'(dx), y: cur.fields.y + 8'(dy), color: color};
	assign valid = active;

endmodule

//--- tb_game_view.sv
/* game view testbench
   loads random item tables, runs two games and checks every pixel write,
   the countdown on the hex digits and the game over level */
`timescale 1ns/1ps
`include "gm_settings.svh"

module tb_game_view
	import gm_pkg::*;
();

	localparam int FRAME_PIX = `SCREEN_W * `SCREEN_H;
	localparam int SPR_PIX = `SPRITE_SIZE * `SPRITE_SIZE;
	// drawing plus a few control cycles per item
	localparam int FRAME_CYCLES = FRAME_PIX + `ITEM_COUNT * (SPR_PIX + 4) + 16;
	localparam int GAME_CYCLES = FRAME_CYCLES + `GAME_SECONDS * `TICKS_PER_SECOND;
	// two games, a quarter game of margin, reset and idle checks
	localparam int WATCHDOG_CYCLES = 2 * GAME_CYCLES + GAME_CYCLES / 4 + 1000;

	logic clk;
	logic rst_n;
	logic go;
	logic item_load;
	logic [`ITEM_IDX_W-1:0] item_index;
	item_word_u item_word;
	pixel_t pixel;
	logic pixel_we;
	logic game_over;
	seg7_t hex0;
	seg7_t hex1;

	integer seed = 32'h095a6eee;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int test_err0 = 0;
	string cur_test = "none";
	// writes seen in the current frame and the number expected
	int wr_count = 0;
	int exp_total = 0;
	bit logging = 0;
	seg7_t hex0_log[$];
	seg7_t hex1_log[$];
	// copy of what was loaded into the table
	item_word_u tb_items[`ITEM_COUNT];

	game_view u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.item_load(item_load),
		.item_index(item_index),
		.item_word(item_word),
		.pixel(pixel),
		.pixel_we(pixel_we),
		.game_over(game_over),
		.hex0(hex0),
		.hex1(hex1)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// palette by kind, empty has no colour
	function automatic logic [11:0] kind_color(item_kind_t kind);
		case (kind)
			KIND_STONE: return `COLOR_STONE;
			KIND_GOLD: return `COLOR_GOLD;
			KIND_DIAMOND: return `COLOR_DIAMOND;
			default: return 12'h000;
		endcase
	endfunction

	// active low gfedcba patterns
	function automatic seg7_t seg_pattern(logic [3:0] d);
		case (d)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	function automatic bit item_drawn(item_fields_t f);
		return f.visible && f.kind != KIND_EMPTY;
	endfunction

	function automatic int frame_writes();
		int n;
		n = FRAME_PIX;
		for (int i = 0; i < `ITEM_COUNT; i++)
			if (item_drawn(tb_items[i].fields))
				n += SPR_PIX;
		return n;
	endfunction

	// n-th write of a frame: background raster first, then drawn items in table order
	function automatic pixel_t ref_pixel(int n);
		pixel_t p;
		item_fields_t f;
		int k;
		p = '0;
		if (n < FRAME_PIX) begin
			p.x = 9'(n % `SCREEN_W);
			p.y = 8'(n / `SCREEN_W);
			p.color = `COLOR_BG;
			return p;
		end
		k = n - FRAME_PIX;
		for (int i = 0; i < `ITEM_COUNT; i++) begin
			f = tb_items[i].fields;
			if (item_drawn(f)) begin
				if (k < SPR_PIX) begin
					p.x = f.x + 9'(k % `SPRITE_SIZE);
					p.y = f.y + 8'(k / `SPRITE_SIZE);
					p.color = kind_color(f.kind);
					return p;
				end
				k -= SPR_PIX;
			end
		end
		return p;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic start_test(string name);
		cur_test = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_err0)
			$display("test %s passed", cur_test);
		else
			$display("test %s FAILED with %0d errors", cur_test, errors - test_err0);
	endtask

	task automatic check_pixel(string what, pixel_t exp, pixel_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error [%s] %s: expected x=%0d y=%0d color=%03h, actual x=%0d y=%0d color=%03h",
				cur_test, what, exp.x, exp.y, exp.color, act.x, act.y, act.color);
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_seg(string what, seg7_t exp, seg7_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error [%s] %s: expected %07b, actual %07b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_count(string what, int exp, int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	// random words, positions kept on screen, pad bits left random
	task automatic load_table(bit force_skip);
		item_word_u w;
		for (int i = 0; i < `ITEM_COUNT; i++) begin
			w.raw = $random(seed);
			w.fields.x = 9'({$random(seed)} % (`SCREEN_W - `SPRITE_SIZE));
			w.fields.y = 8'({$random(seed)} % (`SCREEN_H - `SPRITE_SIZE));
			// second game always has a hidden item and an empty one
			if (force_skip && i == 1)
				w.fields.visible = 1'b0;
			if (force_skip && i == 2) begin
				w.fields.visible = 1'b1;
				w.fields.kind = KIND_EMPTY;
			end
			tb_items[i] = w;
			item_load = 1'b1;
			item_index = `ITEM_IDX_W'(i);
			item_word = w;
			step();
		end
		item_load = 1'b0;
	endtask

	// last GAME_SECONDS+1 display values must step down to zero
	task automatic check_countdown();
		int n;
		int idx;
		int v;
		n = hex0_log.size();
		if (n < `GAME_SECONDS + 1) begin
			errors++;
			$display("[%s] display showed only %0d distinct values, countdown incomplete",
				cur_test, n);
			return;
		end
		for (int j = 0; j <= `GAME_SECONDS; j++) begin
			idx = n - (`GAME_SECONDS + 1) + j;
			v = `GAME_SECONDS - j;
			check_seg($sformatf("hex1 at %0d s", v), seg_pattern(4'(v >> 4)), hex1_log[idx]);
			check_seg($sformatf("hex0 at %0d s", v), seg_pattern(4'(v & 15)), hex0_log[idx]);
		end
	endtask

	task automatic run_game(string name, bit force_skip);
		load_table(force_skip);
		start_test({name, "_frame"});
		exp_total = frame_writes();
		wr_count = 0;
		hex0_log.delete();
		hex1_log.delete();
		logging = 1'b1;
		go = 1'b1;
		step();
		go = 1'b0;
		step();
		check_bit("game_over after go", 1'b0, game_over);
		while (wr_count < exp_total && !game_over)
			step();
		repeat (8) step();
		check_count("pixel writes in frame", exp_total, wr_count);
		end_test();
		start_test({name, "_countdown"});
		while (!game_over)
			step();
		repeat (64) step();
		logging = 1'b0;
		check_bit("game_over at time up", 1'b1, game_over);
		check_count("pixel writes after time up", exp_total, wr_count);
		check_countdown();
		end_test();
	endtask

	// compare every write against the reference at the falling edge
	always @(negedge clk) begin
		if (rst_n && pixel_we) begin
			if (wr_count < exp_total)
				check_pixel($sformatf("pixel %0d", wr_count), ref_pixel(wr_count), pixel);
			else begin
				errors++;
				$display("[%s] pixel write after the frame was already complete", cur_test);
			end
			wr_count++;
		end
	end

	// record each new value shown on the hex digits
	always @(negedge clk) begin
		if (logging) begin
			if (hex0_log.size() == 0 || hex0 !== hex0_log[$] || hex1 !== hex1_log[$]) begin
				hex0_log.push_back(hex0);
				hex1_log.push_back(hex1);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		go = 1'b0;
		item_load = 1'b0;
		item_index = '0;
		item_word = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// idle after reset, nothing drawn
		start_test("reset_state");
		repeat (20) step();
		check_count("pixel writes while idle", 0, wr_count);
		check_bit("game_over after reset", 1'b0, game_over);
		check_seg("hex1 after reset", seg_pattern(4'(`GAME_SECONDS >> 4)), hex1);
		check_seg("hex0 after reset", seg_pattern(4'(`GAME_SECONDS & 15)), hex0);
		end_test();
		run_game("game1", 1'b0);
		run_game("game2", 1'b1);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- view_ctrl.sv
/* view controller
   sequences background, item sprites and the countdown for one game */
`timescale 1ns/1ps
`include "gm_settings.svh"

module view_ctrl
	import gm_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic go,
	input logic bg_done,
	input logic spr_done,
	input logic time_up,
	output logic bg_start,
	output logic spr_start,
	output logic timer_load,
	output logic timer_run,
	output logic [`ITEM_IDX_W-1:0] item_index,
	output draw_src_t src,
	output logic game_over
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_BG,
		ST_ITEM_START,
		ST_ITEM_WAIT,
		ST_PLAY,
		ST_OVER
	} state_t;

	state_t state;
	// index of the item being drawn
	logic [`ITEM_IDX_W-1:0] item_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			item_cnt <= '0;
			bg_start <= 1'b0;
			spr_start <= 1'b0;
			timer_load <= 1'b0;
			game_over <= 1'b0;
		end else begin
			// start strobes are single cycle
			bg_start <= 1'b0;
			spr_start <= 1'b0;
			timer_load <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (go) begin
						state <= ST_BG;
						bg_start <= 1'b1;
					end
				end
				ST_BG: begin
					if (bg_done) begin
						state <= ST_ITEM_START;
						item_cnt <= '0;
					end
				end
				ST_ITEM_START: begin
					// item_index is already stable here, drawer latches it
					spr_start <= 1'b1;
					state <= ST_ITEM_WAIT;
				end
				ST_ITEM_WAIT: begin
					if (spr_done) begin
						if (int'(item_cnt) == `ITEM_COUNT - 1) begin
							state <= ST_PLAY;
							timer_load <= 1'b1;
						end else begin
							item_cnt <= item_cnt + 1'b1;
							state <= ST_ITEM_START;
						end
					end
				end
				ST_PLAY: begin
					// time_up is stale from the last game while the load is pending
					if (time_up && !timer_load) begin
						state <= ST_OVER;
						game_over <= 1'b1;
					end
				end
				ST_OVER: begin
					if (go) begin
						state <= ST_BG;
						bg_start <= 1'b1;
						game_over <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign item_index = item_cnt;
	assign timer_run = (state == ST_PLAY);

	// port ownership follows the state
	always_comb begin
		case (state)
			ST_BG: src = SRC_BG;
			ST_ITEM_START, ST_ITEM_WAIT: src = SRC_SPR;
			default: src = SRC_NONE;
		endcase
	end

endmodule
